/* flist.f */
common/bpuPkg.sv
bpu/branchPredict.sv
bpu/branchQueue.sv
bpu/branchResolve.sv
hdl/bpuTop.sv
tb/bpuTop_props.sv
tb/bpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the BPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module bpuTb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VbpuTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation passed"
exit 0

/* tb/bpuTb.sv */
// BPU testbench with clock, reset, xorshift stimulus, reference model and redirect checks
module bpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import bpuPkg::*;

    localparam int RUN_CYCLES  = 3000;  // Random phase length
    localparam int DRAIN_LIMIT = 40;    // Cycles allowed to empty the queue

    logic        clk;
    logic        rst;
    fetchSlot    fetch;
    resolveSlot  resolve;
    redirectSlot redirect;

    fetchSlot    curFetch;     // Inputs the DUT sees this cycle
    resolveSlot  curResolve;
    branchRecord modelQ [$];   // In-flight branches, oldest first
    logic [1:0]  fwdModel;
    logic [1:0]  bwdModel;
    logic        expValid;     // Redirect expected after the edge
    logic        expFlush;
    logic [31:0] expPc;
    logic [31:0] rngState;
    int          cycle;
    int          waited;
    int          nFlush;       // Stimulus tallies
    int          nBoth;
    int          nSatHigh;
    int          nSatLow;
    int          nBwdTaken;
    int          nFwdNotTaken;

    bpuTop bpuTop_inst (
        .clk      (clk),
        .rst      (rst),
        .fetch    (fetch),
        .resolve  (resolve),
        .redirect (redirect)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] v);
        rngState = xorshift(rngState);
        v = rngState;
    endtask

    // RISC-V B-type offset from the raw word
    function automatic logic [31:0] bImmOf(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // RISC-V J-type offset from the raw word
    function automatic logic [31:0] jImmOf(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [1:0] nextCount(input logic [1:0] cnt, input logic taken);
        logic [1:0] res;
        res = cnt;
        if (taken && cnt != 2'd3) begin
            res = cnt + 2'd1;
        end
        if (!taken && cnt != 2'd0) begin
            res = cnt - 2'd1;
        end
        return res;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic reportValue(input string sigName, input logic [31:0] expVal,
                               input logic [31:0] gotVal);
        failRun($sformatf("FAIL at %0d ns: %s expected %h, got %h",
                          $time, sigName, expVal, gotVal));
    endtask

    // Advance the model by one edge using the inputs of the cycle that ends
    task automatic stepModel();
        branchRecord head;
        branchRecord rec;
        logic [31:0] w;
        logic [1:0]  oldFwd;
        logic [1:0]  oldBwd;
        logic [1:0]  useCnt;
        logic        miss;
        logic [31:0] fixPc;
        logic        predHit;
        logic [31:0] predTarget;
        oldFwd = fwdModel;  // Fetch sees counters before this edge
        oldBwd = bwdModel;
        miss = 1'b0;
        fixPc = '0;
        predHit = 1'b0;
        predTarget = '0;
        if (curResolve.valid && modelQ.size() > 0) begin
            head = modelQ.pop_front();
            useCnt = head.backward ? bwdModel : fwdModel;
            if (curResolve.taken && useCnt == 2'd3) begin
                nSatHigh++;
            end
            if (!curResolve.taken && useCnt == 2'd0) begin
                nSatLow++;
            end
            if (head.backward) begin
                bwdModel = nextCount(bwdModel, curResolve.taken);
            end else begin
                fwdModel = nextCount(fwdModel, curResolve.taken);
            end
            miss  = (curResolve.taken != head.predTaken);
            fixPc = curResolve.taken ? head.targetAddr : head.branchAddr + 32'd4;
            if (miss) begin
                modelQ.delete();  // Younger branches were on the wrong path
                nFlush++;
            end
        end
        if (curFetch.valid) begin
            w = curFetch.instr;
            if (w[6:0] == OPC_BRANCH) begin
                useCnt = w[31] ? oldBwd : oldFwd;
                rec.branchAddr = curFetch.pc;
                rec.targetAddr = curFetch.pc + bImmOf(w);
                rec.backward   = w[31];
                rec.predTaken  = (useCnt >= 2'd2);
                if (!miss) begin
                    modelQ.push_back(rec);  // Dropped when a flush clears the queue
                end
                if (rec.predTaken) begin
                    predHit = 1'b1;
                    predTarget = rec.targetAddr;
                end
                if (rec.backward && rec.predTaken) begin
                    nBwdTaken++;
                end
                if (!rec.backward && !rec.predTaken) begin
                    nFwdNotTaken++;
                end
            end else if (w[6:0] == OPC_JAL) begin
                predHit = 1'b1;
                predTarget = curFetch.pc + jImmOf(w);
            end
        end
        expValid = miss || predHit;
        expFlush = miss;
        expPc    = miss ? fixPc : predTarget;  // Flush wins
        if (miss && predHit) begin
            nBoth++;
        end
    endtask

    task automatic checkRedirect();
        assert (redirect.valid == expValid)
            else reportValue("redirect.valid", {31'b0, expValid}, {31'b0, redirect.valid});
        assert (redirect.flush == expFlush)
            else reportValue("redirect.flush", {31'b0, expFlush}, {31'b0, redirect.flush});
        if (expValid) begin
            assert (redirect.pc == expPc)
                else reportValue("redirect.pc", expPc, redirect.pc);
        end
    endtask

    // Model step and new stimulus at the rising edge then check at the falling edge
    task automatic runCycle(input logic allowFetch);
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] pcRand;
        logic [2:0]  bias;
        fetchSlot    nf;
        resolveSlot  nr;
        @(posedge clk);
        stepModel();
        drawRandom(r);
        drawRandom(w);
        drawRandom(pcRand);
        nf = '0;
        nr = '0;
        case ((cycle / 500) % 3)
            0:       bias = 3'd6;  // Mostly taken
            1:       bias = 3'd1;  // Mostly not taken
            default: bias = 3'd4;
        endcase
        if (allowFetch && r[0]) begin
            case (r[3:1])
                3'd0, 3'd1, 3'd2, 3'd3: begin
                    // Plain ALU op when the queue has no room
                    w[6:0] = (modelQ.size() < QUEUE_DEPTH) ? OPC_BRANCH : 7'b0010011;
                end
                3'd4, 3'd5: begin
                    w[6:0] = OPC_JAL;
                end
                default: begin
                    if (w[6:0] == OPC_BRANCH || w[6:0] == OPC_JAL) begin
                        w[2] = ~w[2];
                    end
                end
            endcase
            nf.valid = 1'b1;
            nf.pc    = {pcRand[31:2], 2'b00};
            nf.instr = w;
        end
        if (modelQ.size() > 0 && (r[8] || !allowFetch)) begin
            nr.valid = 1'b1;
            nr.taken = (r[7:5] < bias);
        end
        fetch   <= nf;
        resolve <= nr;
        curFetch   = nf;
        curResolve = nr;
        cycle++;
        @(negedge clk);
        checkRedirect();
    endtask

    task automatic checkCoverage();
        assert (nFlush > 0) else failRun("No misprediction flush was exercised");
        assert (nBoth > 0) else failRun("No flush coincided with a prediction");
        assert (nSatHigh > 0) else failRun("No counter reached the taken limit");
        assert (nSatLow > 0) else failRun("No counter reached the not-taken limit");
        assert (nBwdTaken > 0) else failRun("No backward branch was predicted taken");
        assert (nFwdNotTaken > 0) else failRun("No forward branch was predicted not taken");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fetch = '0;
        resolve = '0;
        curFetch = '0;
        curResolve = '0;
        fwdModel = 2'd2;  // Weakly taken after reset
        bwdModel = 2'd2;
        expValid = 1'b0;
        expFlush = 1'b0;
        expPc = '0;
        rngState = 32'd36476;
        cycle = 0;
        waited = 0;
        nFlush = 0;
        nBoth = 0;
        nSatHigh = 0;
        nSatLow = 0;
        nBwdTaken = 0;
        nFwdNotTaken = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!redirect.valid && !redirect.flush)
            else failRun("Redirect was active right after reset");
        for (int i = 0; i < RUN_CYCLES; i++) begin
            runCycle(1'b1);
        end
        // Resolve what is left within a bound
        while (modelQ.size() > 0 && waited < DRAIN_LIMIT) begin
            runCycle(1'b0);
            waited++;
        end
        if (modelQ.size() > 0) begin
            failRun("Branch queue did not drain before the timeout");
        end else begin
            runCycle(1'b0);
            runCycle(1'b0);
            checkCoverage();
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* tb/bpuTop_props.sv */
// Bound concurrent checks on branch queue use and redirect form
module bpuProps (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty,
    input logic resolveValid,
    input logic redirectValid,
    input logic redirectFlush
);
    timeunit 1ns;
    timeprecision 100ps;

    // Caller keeps at most QUEUE_DEPTH branches outstanding
    noOverflow: assert property (@(posedge clk) disable iff (rst) !(push && full && !pop))
        else $error("Branch pushed into a full queue");

    noEmptyResolve: assert property (@(posedge clk) disable iff (rst) !(resolveValid && empty))
        else $error("Resolve strobe with an empty queue");

    // Flush only rides on a valid redirect
    flushNeedsValid: assert property (@(posedge clk) disable iff (rst)
        !(redirectFlush && !redirectValid))
        else $error("Redirect flush without valid");

endmodule

bind bpuTop bpuProps bpuProps_inst (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .pop           (pop),
    .full          (full),
    .empty         (empty),
    .resolveValid  (resolve.valid),
    .redirectValid (redirect.valid),
    .redirectFlush (redirect.flush)
);

/* hdl/bpuTop.sv */
// BPU top level connecting predictor, branch queue and resolver
module bpuTop (
    input  logic                clk,
    input  logic                rst,
    input  bpuPkg::fetchSlot    fetch,
    input  bpuPkg::resolveSlot  resolve,
    output bpuPkg::redirectSlot redirect
);
    import bpuPkg::*;

    logic            push;      // Predictor to queue
    branchRecord     pushRec;
    logic            predValid; // Predictor to resolver
    logic [XLEN-1:0] predPc;
    logic [1:0]      fwdCnt;    // Resolver back to predictor
    logic [1:0]      bwdCnt;
    branchRecord     headRec;   // Queue to resolver
    logic            empty;
    logic            full;      // Queue at capacity
    logic            pop;       // Resolver to queue
    logic            clear;

    branchPredict branchPredict_inst (
        .fetch     (fetch),
        .fwdCnt    (fwdCnt),
        .bwdCnt    (bwdCnt),
        .push      (push),
        .pushRec   (pushRec),
        .predValid (predValid),
        .predPc    (predPc)
    );

    branchQueue branchQueue_inst (
        .clk     (clk),
        .rst     (rst),
        .push    (push),
        .pushRec (pushRec),
        .pop     (pop),
        .clear   (clear),
        .headRec (headRec),
        .empty   (empty),
        .full    (full)
    );

    branchResolve branchResolve_inst (
        .clk       (clk),
        .rst       (rst),
        .resolve   (resolve),
        .headRec   (headRec),
        .empty     (empty),
        .predValid (predValid),
        .predPc    (predPc),
        .pop       (pop),
        .clear     (clear),
        .fwdCnt    (fwdCnt),
        .bwdCnt    (bwdCnt),
        .redirect  (redirect)
    );

endmodule

/* bpu/branchResolve.sv */
// Branch resolver with direction counters, misprediction check and registered redirect
module branchResolve (
    input  logic                    clk,
    input  logic                    rst,
    input  bpuPkg::resolveSlot      resolve,
    input  bpuPkg::branchRecord     headRec,
    input  logic                    empty,
    input  logic                    predValid,
    input  logic [bpuPkg::XLEN-1:0] predPc,
    output logic                    pop,
    output logic                    clear,
    output logic [1:0]              fwdCnt,
    output logic [1:0]              bwdCnt,
    output bpuPkg::redirectSlot     redirect
);
    import bpuPkg::*;

    logic            mismatch;  // Outcome differs from guess
    logic [XLEN-1:0] fixPc;     // Correct path after a miss
    logic [XLEN-1:0] nextPc;

    // Saturating step toward the real outcome
    function automatic logic [1:0] satStep(input logic [1:0] cnt, input logic taken);
        logic [1:0] nxt;
        nxt = cnt;
        if (taken && (cnt != 2'd3)) begin
            nxt = cnt + 2'd1;
        end else if (!taken && (cnt != 2'd0)) begin
            nxt = cnt - 2'd1;
        end
        return nxt;
    endfunction

    assign pop      = resolve.valid && !empty;  // Head retires on each resolve
    assign mismatch = pop && (resolve.taken != headRec.predTaken);
    assign clear    = mismatch;                 // Younger entries are wrong path

    // Taken goes to target and not taken falls through
    assign fixPc  = resolve.taken ? headRec.targetAddr : headRec.branchAddr + XLEN'(4);
    assign nextPc = mismatch ? fixPc : predPc;  // Miss wins over prediction

    // Only the retiring branch's direction moves
    always_ff @(posedge clk) begin
        if (rst) begin
            fwdCnt <= CNT_INIT;
            bwdCnt <= CNT_INIT;
        end else if (pop) begin
            if (headRec.backward) begin
                bwdCnt <= satStep(bwdCnt, resolve.taken);
            end else begin
                fwdCnt <= satStep(fwdCnt, resolve.taken);
            end
        end
    end

    // Redirect control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect.valid <= 1'b0;
            redirect.flush <= 1'b0;
        end else begin
            redirect.valid <= mismatch || predValid;
            redirect.flush <= mismatch;
        end
    end

    // Redirect address
    always_ff @(posedge clk) begin
        redirect.pc <= nextPc;
    end

endmodule

/* bpu/branchQueue.sv */
// Branch queue as a circular FIFO of in-flight branch records with clear
module branchQueue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  bpuPkg::branchRecord pushRec,
    input  logic                pop,
    input  logic                clear,
    output bpuPkg::branchRecord headRec,
    output logic                empty,
    output logic                full
);
    import bpuPkg::*;

    branchRecord      mem [QUEUE_DEPTH];  // Record storage
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;              // Occupancy
    logic             doPush;
    logic             doPop;

    // Clear beats a push in the same cycle
    assign doPush = push && !clear;
    assign doPop  = pop && !clear && !empty;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign headRec = mem[rdPtr];  // Oldest record

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = ptr + 1'b1;
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            nxt = '0;  // Wrap
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushRec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

/* bpu/branchPredict.sv */
// Branch predictor with fetch decode, B and J target adders, prediction and queue record
module branchPredict (
    input  bpuPkg::fetchSlot          fetch,
    input  logic [1:0]                fwdCnt,
    input  logic [1:0]                bwdCnt,
    output logic                      push,
    output bpuPkg::branchRecord       pushRec,
    output logic                      predValid,
    output logic [bpuPkg::XLEN-1:0]   predPc
);
    import bpuPkg::*;

    logic            isBranch;  // Conditional branch in this fetch
    logic            isJal;     // Unconditional jump in this fetch
    logic [XLEN-1:0] bImm;
    logic [XLEN-1:0] jImm;
    logic [XLEN-1:0] bTarget;
    logic [XLEN-1:0] jTarget;
    logic            bBackward;
    logic [1:0]      selCnt;
    logic            bTaken;

    // Opcode lives at the same bits in both views
    assign isBranch = fetch.valid && (fetch.instr.b.opcode == OPC_BRANCH);
    assign isJal    = fetch.valid && (fetch.instr.j.opcode == OPC_JAL);

    // B-type offset with bit 0 always zero
    assign bImm = {
        {(XLEN-12){fetch.instr.b.imm12}},
        fetch.instr.b.imm11,
        fetch.instr.b.imm10to5,
        fetch.instr.b.imm4to1,
        1'b0
    };

    // J-type offset with bit 0 always zero
    assign jImm = {
        {(XLEN-20){fetch.instr.j.imm20}},
        fetch.instr.j.imm19to12,
        fetch.instr.j.imm11,
        fetch.instr.j.imm10to1,
        1'b0
    };

    assign bTarget = fetch.pc + bImm;  // Branch destination
    assign jTarget = fetch.pc + jImm;  // Jump destination

    // Direction from the offset sign
    assign bBackward = fetch.instr.b.imm12;
    assign selCnt    = bBackward ? bwdCnt : fwdCnt;
    assign bTaken    = (selCnt >= 2'd2);  // Upper half of the counter

    // Every conditional branch is queued
    assign push = isBranch;

    always_comb begin
        pushRec.branchAddr = fetch.pc;
        pushRec.targetAddr = bTarget;
        pushRec.backward   = bBackward;
        pushRec.predTaken  = bTaken;
    end

    // JAL always redirects and is never queued
    always_comb begin
        predValid = 1'b0;
        predPc    = bTarget;
        if (isJal) begin
            predValid = 1'b1;
            predPc    = jTarget;
        end else if (isBranch && bTaken) begin
            predValid = 1'b1;  // Taken guess
        end
    end

endmodule

/* common/bpuPkg.sv */
// BPU package with widths, queue depth, opcodes, instruction union and slot structs
package bpuPkg;

    localparam int XLEN = 32;                       // Address and instruction width
    localparam int QUEUE_DEPTH = 4;                 // In-flight branch records
    localparam int PTR_W = $clog2(QUEUE_DEPTH);     // Queue pointer width
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1); // Queue occupancy width

    localparam logic [1:0] CNT_INIT = 2'd2;         // Weakly taken after reset

    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // B-type conditional branch
    localparam logic [6:0] OPC_JAL = 7'b1101111;    // Jump and link

    // B-type layout with MSB first
    typedef struct packed {
        logic       imm12;      // Sign bit of the offset
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFields;

    // J-type layout with MSB first
    typedef struct packed {
        logic       imm20;      // Sign bit of the offset
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFields;

    // Same fetched word seen as either format
    typedef union packed {
        bFields b;
        jFields j;
    } instrWord;

    typedef struct packed {
        logic            valid;  // One-cycle fetch strobe
        logic [XLEN-1:0] pc;
        instrWord        instr;
    } fetchSlot;

    typedef struct packed {
        logic valid;             // One-cycle resolve strobe
        logic taken;             // Real outcome from execute
    } resolveSlot;

    typedef struct packed {
        logic [XLEN-1:0] branchAddr; // PC of the branch itself
        logic [XLEN-1:0] targetAddr; // PC plus B immediate
        logic            backward;   // Negative offset
        logic            predTaken;  // Prediction made at fetch
    } branchRecord;

    typedef struct packed {
        logic            valid;
        logic            flush;  // Set only for a misprediction
        logic [XLEN-1:0] pc;
    } redirectSlot;

endpackage
